/* hdl/corr_pkg.sv */
package corr_pkg;

   // Datapath widths.
   localparam int SAMPLE_W  = 4;
   localparam int ACC_W     = 14;
   localparam int POWER_W   = 27;
   localparam int INT_LEN_W = 10;
   localparam int COUNT_W   = 16;
   localparam int APB_AW    = 8;
   localparam int APB_DW    = 32;

   // Early, prompt and late.
   localparam int NUM_TAPS = 3;

   typedef logic signed [SAMPLE_W-1:0] sample_t;
   typedef logic signed [ACC_W-1:0]    acc_t;
   typedef logic [POWER_W-1:0]         power_t;
   typedef logic [INT_LEN_W-1:0]       int_len_t;
   typedef logic [COUNT_W-1:0]         count_t;
   typedef logic [APB_AW-1:0]          apb_addr_t;
   typedef logic [APB_DW-1:0]          apb_data_t;
   typedef logic [1:0]                 tap_idx_t;

   // Integration length limits, in samples.
   localparam int_len_t INT_LEN_MIN   = 10'd8;
   localparam int_len_t INT_LEN_RESET = 10'd16;

   // Register map.
   localparam apb_addr_t ADDR_CTRL    = 8'h00;
   localparam apb_addr_t ADDR_INT_LEN = 8'h04;
   localparam apb_addr_t ADDR_COUNT   = 8'h08;

   // Power detector sequencing.
   typedef enum logic {
      IDLE,
      SQUARE
   } pd_state_t;

   // Last accepted sample to o_power_valid, in cycles.
   localparam int POWER_LATENCY = 6;

endpackage

/* hdl/tap_bus_if.sv */
interface tap_bus_if;

   // One item per accepted sample.
   logic                             valid;
   corr_pkg::sample_t                sample_i;
   corr_pkg::sample_t                sample_q;
   logic [corr_pkg::NUM_TAPS-1:0]    chips;

   // Period boundary markers.
   logic                             first;
   logic                             last;

   modport source (
      output valid,
      output sample_i,
      output sample_q,
      output chips,
      output first,
      output last
   );

   modport sink (
      input valid,
      input sample_i,
      input sample_q,
      input chips,
      input first,
      input last
   );

endinterface

/* hdl/apb_regs.sv */
module apb_regs (
   input  logic                 clk,
   input  logic                 i_rst_n,
   input  logic                 i_psel,
   input  logic                 i_penable,
   input  logic                 i_pwrite,
   input  corr_pkg::apb_addr_t  i_paddr,
   input  corr_pkg::apb_data_t  i_pwdata,
   input  logic                 i_power_valid,
   output corr_pkg::apb_data_t  o_prdata,
   output logic                 o_pready,
   output logic                 o_pslverr,
   output logic                 o_enable,
   output corr_pkg::int_len_t   o_int_len
);

   corr_pkg::count_t    count;
   corr_pkg::int_len_t  wr_len;
   corr_pkg::apb_data_t rd_data;
   logic                addr_ok;
   logic                access;

   // No wait states.
   assign o_pready = 1'b1;

   assign access = i_psel && i_penable;
   assign wr_len = i_pwdata[corr_pkg::INT_LEN_W-1:0];

   always_comb begin
      addr_ok = 1'b1;
      rd_data = '0;
      case (i_paddr)
         corr_pkg::ADDR_CTRL:    rd_data = corr_pkg::apb_data_t'(o_enable);
         corr_pkg::ADDR_INT_LEN: rd_data = corr_pkg::apb_data_t'(o_int_len);
         corr_pkg::ADDR_COUNT:   rd_data = corr_pkg::apb_data_t'(count);
         default:                addr_ok = 1'b0;
      endcase
   end

   // Read data and error are valid in the access phase.
   assign o_prdata  = rd_data;
   assign o_pslverr = access && !addr_ok;

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         o_enable  <= 1'b0;
         o_int_len <= corr_pkg::INT_LEN_RESET;
      end else if (access && i_pwrite) begin
         if (i_paddr == corr_pkg::ADDR_CTRL) begin
            o_enable <= i_pwdata[0];
         end
         if (i_paddr == corr_pkg::ADDR_INT_LEN) begin
            // Short periods would overrun the power detector.
            if (wr_len < corr_pkg::INT_LEN_MIN) begin
               o_int_len <= corr_pkg::INT_LEN_MIN;
            end else begin
               o_int_len <= wr_len;
            end
         end
      end
   end

   // Completed periods.
   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         count <= '0;
      end else if (i_power_valid) begin
         count <= count + corr_pkg::count_t'(1);
      end
   end

endmodule

/* hdl/code_tap_line.sv */
module code_tap_line #(
   parameter int SPACING = 2
) (
   input  logic                clk,
   input  logic                i_rst_n,
   input  logic                i_enable,
   input  corr_pkg::int_len_t  i_int_len,
   input  logic                i_sample_valid,
   input  corr_pkg::sample_t   i_sample_i,
   input  corr_pkg::sample_t   i_sample_q,
   input  logic                i_code_chip,
   tap_bus_if.source           bus
);

   // Early at stage 0, each later tap SPACING stages further down.
   localparam int LINE_LEN = (corr_pkg::NUM_TAPS - 1) * SPACING + 1;

   logic [LINE_LEN-1:0] chip_line;
   corr_pkg::int_len_t  cnt;
   corr_pkg::int_len_t  len_q;
   corr_pkg::int_len_t  len_cur;
   logic                accept;
   logic                first;
   logic                last;

   assign accept = i_sample_valid && i_enable;

   // Count of zero means the next sample opens a period.
   assign first   = (cnt == '0);
   assign len_cur = first ? i_int_len : len_q;
   assign last    = (cnt == len_cur - corr_pkg::int_len_t'(1));

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         cnt <= '0;
      end else if (!i_enable) begin
         cnt <= '0;
      end else if (accept) begin
         if (last) begin
            cnt <= '0;
         end else begin
            cnt <= cnt + corr_pkg::int_len_t'(1);
         end
      end
   end

   always_ff @(posedge clk) begin
      if (accept && first) begin
         len_q <= i_int_len;
      end
   end

   // Chip history survives a disable.
   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         chip_line <= '0;
      end else if (accept) begin
         chip_line <= {chip_line[LINE_LEN-2:0], i_code_chip};
      end
   end

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         bus.valid <= 1'b0;
      end else begin
         bus.valid <= accept;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         bus.sample_i <= i_sample_i;
         bus.sample_q <= i_sample_q;
         bus.first    <= first;
         bus.last     <= last;
      end
   end

   // Chips follow the line, which moves only with the samples.
   for (genvar t = 0; t < corr_pkg::NUM_TAPS; t++) begin : g_tap
      assign bus.chips[t] = chip_line[t * SPACING];
   end

endmodule

/* hdl/correlator.sv */
module correlator #(
   parameter int TAP = 0
) (
   input  logic            clk,
   input  logic            i_rst_n,
   tap_bus_if.sink         bus,
   output logic            o_dump,
   output corr_pkg::acc_t  o_acc_i,
   output corr_pkg::acc_t  o_acc_q
);

   corr_pkg::acc_t acc_i;
   corr_pkg::acc_t acc_q;
   corr_pkg::acc_t base_i;
   corr_pkg::acc_t base_q;
   corr_pkg::acc_t ext_i;
   corr_pkg::acc_t ext_q;
   corr_pkg::acc_t sum_i;
   corr_pkg::acc_t sum_q;

   always_comb begin
      base_i = bus.first ? '0 : acc_i;
      base_q = bus.first ? '0 : acc_q;
      // Widen before negating so -8 stays exact.
      ext_i  = corr_pkg::acc_t'(bus.sample_i);
      ext_q  = corr_pkg::acc_t'(bus.sample_q);
      sum_i  = bus.chips[TAP] ? base_i + ext_i : base_i - ext_i;
      sum_q  = bus.chips[TAP] ? base_q + ext_q : base_q - ext_q;
   end

   always_ff @(posedge clk) begin
      if (bus.valid) begin
         acc_i <= sum_i;
         acc_q <= sum_q;
      end
      if (bus.valid && bus.last) begin
         o_acc_i <= sum_i;
         o_acc_q <= sum_q;
      end
   end

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         o_dump <= 1'b0;
      end else begin
         o_dump <= bus.valid && bus.last;
      end
   end

endmodule

/* hdl/power_detector.sv */
module power_detector (
   input  logic                          clk,
   input  logic                          i_rst_n,
   input  logic [corr_pkg::NUM_TAPS-1:0] i_dump,
   input  corr_pkg::acc_t                i_acc_i [corr_pkg::NUM_TAPS],
   input  corr_pkg::acc_t                i_acc_q [corr_pkg::NUM_TAPS],
   output logic                          o_power_valid,
   output corr_pkg::power_t              o_power_early,
   output corr_pkg::power_t              o_power_prompt,
   output corr_pkg::power_t              o_power_late
);

   localparam corr_pkg::tap_idx_t LAST_TAP = corr_pkg::tap_idx_t'(corr_pkg::NUM_TAPS - 1);

   corr_pkg::pd_state_t      state;
   corr_pkg::tap_idx_t       idx;
   corr_pkg::acc_t           cap_i [corr_pkg::NUM_TAPS];
   corr_pkg::acc_t           cap_q [corr_pkg::NUM_TAPS];

   // Issue slot.
   logic                     iss_valid;
   corr_pkg::tap_idx_t       iss_idx;
   corr_pkg::acc_t           iss_i;
   corr_pkg::acc_t           iss_q;

   // Squarer stage 1 holds magnitudes, stage 2 the squares.
   logic                     s1_valid;
   corr_pkg::tap_idx_t       s1_idx;
   logic [corr_pkg::ACC_W-1:0] s1_mag_i;
   logic [corr_pkg::ACC_W-1:0] s1_mag_q;
   logic                     s2_valid;
   corr_pkg::tap_idx_t       s2_idx;
   corr_pkg::power_t         s2_sq_i;
   corr_pkg::power_t         s2_sq_q;

   logic                     start;

   function automatic logic [corr_pkg::ACC_W-1:0] magnitude(input corr_pkg::acc_t x);
      magnitude = x[corr_pkg::ACC_W-1] ? -x : x;
   endfunction

   assign start = (state == corr_pkg::IDLE) && i_dump[0];

   // Tap 0 goes straight from the correlators on the dump cycle.
   always_comb begin
      iss_valid = 1'b0;
      iss_idx   = '0;
      iss_i     = i_acc_i[0];
      iss_q     = i_acc_q[0];
      case (state)
         corr_pkg::IDLE: begin
            iss_valid = i_dump[0];
         end
         corr_pkg::SQUARE: begin
            iss_valid = 1'b1;
            iss_idx   = idx;
            iss_i     = cap_i[idx];
            iss_q     = cap_q[idx];
         end
         default: begin
            iss_valid = 1'b0;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         state <= corr_pkg::IDLE;
         idx   <= '0;
      end else begin
         case (state)
            corr_pkg::IDLE: begin
               if (i_dump[0]) begin
                  state <= corr_pkg::SQUARE;
                  idx   <= corr_pkg::tap_idx_t'(1);
               end
            end
            corr_pkg::SQUARE: begin
               if (idx == LAST_TAP) begin
                  state <= corr_pkg::IDLE;
               end
               idx <= idx + corr_pkg::tap_idx_t'(1);
            end
            default: begin
               state <= corr_pkg::IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         s1_valid      <= 1'b0;
         s2_valid      <= 1'b0;
         o_power_valid <= 1'b0;
      end else begin
         s1_valid      <= iss_valid;
         s2_valid      <= s1_valid;
         o_power_valid <= s2_valid && (s2_idx == LAST_TAP);
      end
   end

   always_ff @(posedge clk) begin
      if (start) begin
         cap_i <= i_acc_i;
         cap_q <= i_acc_q;
      end
      s1_idx   <= iss_idx;
      s1_mag_i <= magnitude(iss_i);
      s1_mag_q <= magnitude(iss_q);
      s2_idx   <= s1_idx;
      s2_sq_i  <= corr_pkg::power_t'(s1_mag_i) * corr_pkg::power_t'(s1_mag_i);
      s2_sq_q  <= corr_pkg::power_t'(s1_mag_q) * corr_pkg::power_t'(s1_mag_q);
      // Adder stage writes straight into the tap's output.
      if (s2_valid) begin
         case (s2_idx)
            2'd0:    o_power_early  <= s2_sq_i + s2_sq_q;
            2'd1:    o_power_prompt <= s2_sq_i + s2_sq_q;
            default: o_power_late   <= s2_sq_i + s2_sq_q;
         endcase
      end
   end

endmodule

/* hdl/channel_top.sv */
module channel_top #(
   parameter int SPACING = 2
) (
   input  logic                 clk,
   input  logic                 i_rst_n,
   // APB configuration port.
   input  logic                 i_psel,
   input  logic                 i_penable,
   input  logic                 i_pwrite,
   input  corr_pkg::apb_addr_t  i_paddr,
   input  corr_pkg::apb_data_t  i_pwdata,
   output corr_pkg::apb_data_t  o_prdata,
   output logic                 o_pready,
   output logic                 o_pslverr,
   // Baseband samples and code chips.
   input  logic                 i_sample_valid,
   input  corr_pkg::sample_t    i_sample_i,
   input  corr_pkg::sample_t    i_sample_q,
   input  logic                 i_code_chip,
   // Per-period tap powers.
   output logic                 o_power_valid,
   output corr_pkg::power_t     o_power_early,
   output corr_pkg::power_t     o_power_prompt,
   output corr_pkg::power_t     o_power_late
);

   logic                          enable;
   corr_pkg::int_len_t            int_len;
   logic [corr_pkg::NUM_TAPS-1:0] dump;
   corr_pkg::acc_t                acc_i [corr_pkg::NUM_TAPS];
   corr_pkg::acc_t                acc_q [corr_pkg::NUM_TAPS];

   tap_bus_if tap_bus ();

   apb_regs u_regs (
      .clk           (clk),
      .i_rst_n       (i_rst_n),
      .i_psel        (i_psel),
      .i_penable     (i_penable),
      .i_pwrite      (i_pwrite),
      .i_paddr       (i_paddr),
      .i_pwdata      (i_pwdata),
      .i_power_valid (o_power_valid),
      .o_prdata      (o_prdata),
      .o_pready      (o_pready),
      .o_pslverr     (o_pslverr),
      .o_enable      (enable),
      .o_int_len     (int_len)
   );

   code_tap_line #(
      .SPACING (SPACING)
   ) u_tap_line (
      .clk            (clk),
      .i_rst_n        (i_rst_n),
      .i_enable       (enable),
      .i_int_len      (int_len),
      .i_sample_valid (i_sample_valid),
      .i_sample_i     (i_sample_i),
      .i_sample_q     (i_sample_q),
      .i_code_chip    (i_code_chip),
      .bus            (tap_bus.source)
   );

   // Early, prompt and late correlators.
   for (genvar t = 0; t < corr_pkg::NUM_TAPS; t++) begin : g_corr
      correlator #(
         .TAP (t)
      ) u_corr (
         .clk     (clk),
         .i_rst_n (i_rst_n),
         .bus     (tap_bus.sink),
         .o_dump  (dump[t]),
         .o_acc_i (acc_i[t]),
         .o_acc_q (acc_q[t])
      );
   end

   power_detector u_power (
      .clk            (clk),
      .i_rst_n        (i_rst_n),
      .i_dump         (dump),
      .i_acc_i        (acc_i),
      .i_acc_q        (acc_q),
      .o_power_valid  (o_power_valid),
      .o_power_early  (o_power_early),
      .o_power_prompt (o_power_prompt),
      .o_power_late   (o_power_late)
   );

endmodule

/* dv/channel_checker.sv */
module channel_checker #(
   parameter int SPACING = 2
) (
   input  logic                 clk,
   input  logic                 i_rst_n,
   input  logic                 i_psel,
   input  logic                 i_penable,
   input  logic                 i_pwrite,
   input  corr_pkg::apb_addr_t  i_paddr,
   input  corr_pkg::apb_data_t  i_pwdata,
   input  logic                 i_sample_valid,
   input  corr_pkg::sample_t    i_sample_i,
   input  corr_pkg::sample_t    i_sample_q,
   input  logic                 i_code_chip,
   input  logic                 i_power_valid,
   input  corr_pkg::power_t     i_power_early,
   input  corr_pkg::power_t     i_power_prompt,
   input  corr_pkg::power_t     i_power_late,
   output int                   o_errors,
   output int                   o_checks,
   output int                   o_pulses
);

   localparam int LINE_LEN = 2 * SPACING + 1;
   localparam int NTAPS    = 3;

   // Mirror of the register and period state.
   logic enable_m;
   int   len_reg;
   int   len_cur;
   int   cnt;
   logic hist [LINE_LEN];
   int   sum_i [NTAPS];
   int   sum_q [NTAPS];
   int   cyc = 0;

   // Expected results, oldest first.
   int   exp_early [$];
   int   exp_prompt [$];
   int   exp_late [$];
   int   exp_cyc [$];

   int   errors = 0;
   int   checks = 0;
   int   pulses = 0;

   assign o_errors = errors;
   assign o_checks = checks;
   assign o_pulses = pulses;

   task automatic compare_power(input string name, input int expected, input int actual);
      checks++;
      if (expected != actual) begin
         errors++;
         $display("[ERROR] %0t %s expected %0d actual %0d", $time, name, expected, actual);
      end
   endtask

   // Inputs are stable at the rising edge.
   always @(posedge clk) begin : model
      int k;
      int t;
      int s_i;
      int s_q;
      int wr_len;
      cyc = cyc + 1;
      if (!i_rst_n) begin
         enable_m = 1'b0;
         len_reg  = int'(corr_pkg::INT_LEN_RESET);
         len_cur  = len_reg;
         cnt      = 0;
         for (k = 0; k < LINE_LEN; k++) begin
            hist[k] = 1'b0;
         end
         exp_early.delete();
         exp_prompt.delete();
         exp_late.delete();
         exp_cyc.delete();
      end else begin
         if (i_sample_valid && enable_m) begin
            if (cnt == 0) begin
               len_cur = len_reg;
               for (t = 0; t < NTAPS; t++) begin
                  sum_i[t] = 0;
                  sum_q[t] = 0;
               end
            end
            for (k = LINE_LEN - 1; k > 0; k--) begin
               hist[k] = hist[k-1];
            end
            hist[0] = i_code_chip;
            s_i = int'(i_sample_i);
            s_q = int'(i_sample_q);
            // Early sees this chip, later taps SPACING samples older each.
            for (t = 0; t < NTAPS; t++) begin
               if (hist[t * SPACING]) begin
                  sum_i[t] = sum_i[t] + s_i;
                  sum_q[t] = sum_q[t] + s_q;
               end else begin
                  sum_i[t] = sum_i[t] - s_i;
                  sum_q[t] = sum_q[t] - s_q;
               end
            end
            cnt = cnt + 1;
            if (cnt == len_cur) begin
               exp_early.push_back(sum_i[0] * sum_i[0] + sum_q[0] * sum_q[0]);
               exp_prompt.push_back(sum_i[1] * sum_i[1] + sum_q[1] * sum_q[1]);
               exp_late.push_back(sum_i[2] * sum_i[2] + sum_q[2] * sum_q[2]);
               exp_cyc.push_back(cyc);
               cnt = 0;
            end
         end else if (!enable_m) begin
            cnt = 0;
         end
         // Register writes land after this edge's sample.
         if (i_psel && i_penable && i_pwrite) begin
            if (i_paddr == corr_pkg::ADDR_CTRL) begin
               enable_m = i_pwdata[0];
            end
            if (i_paddr == corr_pkg::ADDR_INT_LEN) begin
               wr_len  = int'(i_pwdata[9:0]);
               len_reg = (wr_len < 8) ? 8 : wr_len;
            end
         end
      end
   end

   // Outputs are registered, so they are settled by the falling edge.
   always @(negedge clk) begin : compare
      int lat;
      if (i_power_valid === 1'b1) begin
         pulses++;
         if (exp_cyc.size() == 0) begin
            errors++;
            $display("o_power_valid rose at %0t with no completed period", $time);
         end else begin
            lat = cyc - exp_cyc.pop_front();
            checks++;
            if (lat != corr_pkg::POWER_LATENCY) begin
               errors++;
               $display("[ERROR] %0t o_power_valid latency expected %0d actual %0d",
                        $time, corr_pkg::POWER_LATENCY, lat);
            end
            compare_power("o_power_early", exp_early.pop_front(), int'(i_power_early));
            compare_power("o_power_prompt", exp_prompt.pop_front(), int'(i_power_prompt));
            compare_power("o_power_late", exp_late.pop_front(), int'(i_power_late));
         end
      end
   end

endmodule

/* dv/tb_channel.sv */
module tb_channel;

   localparam int SPACING         = 2;
   localparam int NUM_TESTS       = 4;
   localparam int WAIT_LIMIT      = 400;
   localparam int MODE_PLAIN      = 0;
   localparam int MODE_LEN_CHANGE = 1;
   localparam int MODE_DISABLE    = 2;

   typedef struct packed {
      int len;
      int alt_len;
      int periods;
      int gap;
      int mode;
   } row_t;

   // Length, length written mid-period, periods, largest gap, mode.
   row_t stim_rows [NUM_TESTS] = '{
      '{16, 16, 4, 0, MODE_PLAIN},
      '{8, 8, 6, 0, MODE_PLAIN},
      '{12, 10, 3, 3, MODE_LEN_CHANGE},
      '{10, 10, 3, 2, MODE_DISABLE}
   };

   logic                clk;
   logic                rst_n;
   logic                psel;
   logic                penable;
   logic                pwrite;
   corr_pkg::apb_addr_t paddr;
   corr_pkg::apb_data_t pwdata;
   corr_pkg::apb_data_t prdata;
   logic                pready;
   logic                pslverr;
   logic                sample_valid;
   corr_pkg::sample_t   sample_i;
   corr_pkg::sample_t   sample_q;
   logic                code_chip;
   logic                power_valid;
   corr_pkg::power_t    power_early;
   corr_pkg::power_t    power_prompt;
   corr_pkg::power_t    power_late;

   int seed      = 32'hd3e6;
   int tb_errors = 0;
   int tb_checks = 0;
   int chk_errors;
   int chk_checks;
   int chk_pulses;

   channel_top #(
      .SPACING (SPACING)
   ) DUT (
      .clk            (clk),
      .i_rst_n        (rst_n),
      .i_psel         (psel),
      .i_penable      (penable),
      .i_pwrite       (pwrite),
      .i_paddr        (paddr),
      .i_pwdata       (pwdata),
      .o_prdata       (prdata),
      .o_pready       (pready),
      .o_pslverr      (pslverr),
      .i_sample_valid (sample_valid),
      .i_sample_i     (sample_i),
      .i_sample_q     (sample_q),
      .i_code_chip    (code_chip),
      .o_power_valid  (power_valid),
      .o_power_early  (power_early),
      .o_power_prompt (power_prompt),
      .o_power_late   (power_late)
   );

   channel_checker #(
      .SPACING (SPACING)
   ) u_checker (
      .clk            (clk),
      .i_rst_n        (rst_n),
      .i_psel         (psel),
      .i_penable      (penable),
      .i_pwrite       (pwrite),
      .i_paddr        (paddr),
      .i_pwdata       (pwdata),
      .i_sample_valid (sample_valid),
      .i_sample_i     (sample_i),
      .i_sample_q     (sample_q),
      .i_code_chip    (code_chip),
      .i_power_valid  (power_valid),
      .i_power_early  (power_early),
      .i_power_prompt (power_prompt),
      .i_power_late   (power_late),
      .o_errors       (chk_errors),
      .o_checks       (chk_checks),
      .o_pulses       (chk_pulses)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   function automatic string mode_name(input int mode);
      case (mode)
         MODE_LEN_CHANGE: mode_name = "length change";
         MODE_DISABLE:    mode_name = "disable";
         default:         mode_name = "plain";
      endcase
   endfunction

   task automatic check_value(input string name, input int expected, input int actual);
      tb_checks++;
      if (expected != actual) begin
         tb_errors++;
         $display("[ERROR] %0t %s expected %0d actual %0d", $time, name, expected, actual);
      end
   endtask

   // Setup phase, access phase, then results taken on the next falling edge.
   task automatic apb_access(input logic write, input corr_pkg::apb_addr_t addr,
                             input int wdata, output int rdata, output int err);
      @(negedge clk);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = write;
      paddr   = addr;
      pwdata  = corr_pkg::apb_data_t'(wdata);
      @(negedge clk);
      penable = 1'b1;
      @(negedge clk);
      rdata   = int'(prdata);
      err     = int'(pslverr);
      check_value("o_pready", 1, int'(pready));
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic send_samples(input int count, input int gap_max);
      int k;
      int n;
      int g;
      logic [31:0] r;
      for (k = 0; k < count; k++) begin
         @(negedge clk);
         sample_valid = 1'b1;
         sample_i     = corr_pkg::sample_t'($random(seed));
         sample_q     = corr_pkg::sample_t'($random(seed));
         r            = $random(seed);
         code_chip    = r[0];
         if (gap_max > 0) begin
            g = int'($unsigned($random(seed)) % (gap_max + 1));
            for (n = 0; n < g; n++) begin
               @(negedge clk);
               sample_valid = 1'b0;
            end
         end
      end
      @(negedge clk);
      sample_valid = 1'b0;
   endtask

   task automatic wait_pulses(input int target);
      int n;
      n = 0;
      while (chk_pulses < target && n < WAIT_LIMIT) begin
         @(posedge clk);
         n++;
      end
      if (chk_pulses < target) begin
         tb_errors++;
         $display("Timeout after %0d cycles: saw %0d power results, wanted %0d",
                  WAIT_LIMIT, chk_pulses, target);
      end
   endtask

   task automatic register_test();
      int rd;
      int err;
      apb_access(1'b0, corr_pkg::ADDR_CTRL, 0, rd, err);
      check_value("CTRL", 0, rd);
      check_value("o_pslverr", 0, err);
      apb_access(1'b0, corr_pkg::ADDR_INT_LEN, 0, rd, err);
      check_value("INT_LEN", 16, rd);
      apb_access(1'b0, corr_pkg::ADDR_COUNT, 0, rd, err);
      check_value("COUNT", 0, rd);
      // Below the minimum, so the register clamps.
      apb_access(1'b1, corr_pkg::ADDR_INT_LEN, 3, rd, err);
      apb_access(1'b0, corr_pkg::ADDR_INT_LEN, 0, rd, err);
      check_value("INT_LEN", 8, rd);
      apb_access(1'b0, 8'h0c, 0, rd, err);
      check_value("o_pslverr", 1, err);
      check_value("o_prdata", 0, rd);
      apb_access(1'b1, 8'h0c, 32, rd, err);
      check_value("o_pslverr", 1, err);
      apb_access(1'b0, corr_pkg::ADDR_INT_LEN, 0, rd, err);
      check_value("INT_LEN", 8, rd);
      $display("Test 0 (registers): %0d errors", tb_errors);
   endtask

   task automatic run_row(input int idx);
      row_t r;
      int   base;
      int   err0;
      int   total;
      int   rd;
      int   err;
      r = stim_rows[idx];
      @(posedge clk);
      base = chk_pulses;
      err0 = tb_errors + chk_errors;
      apb_access(1'b1, corr_pkg::ADDR_INT_LEN, r.len, rd, err);
      apb_access(1'b1, corr_pkg::ADDR_CTRL, 1, rd, err);
      case (r.mode)
         MODE_LEN_CHANGE: begin
            send_samples(r.len / 2, r.gap);
            apb_access(1'b1, corr_pkg::ADDR_INT_LEN, r.alt_len, rd, err);
            send_samples(r.len - r.len / 2 + (r.periods - 1) * r.alt_len, r.gap);
         end
         MODE_DISABLE: begin
            send_samples(r.len / 2, r.gap);
            apb_access(1'b1, corr_pkg::ADDR_CTRL, 0, rd, err);
            send_samples(r.len, r.gap);
            repeat (corr_pkg::POWER_LATENCY + 2) @(posedge clk);
            tb_checks++;
            if (chk_pulses != base) begin
               tb_errors++;
               $display("Power result appeared while the channel was disabled");
            end
            apb_access(1'b1, corr_pkg::ADDR_CTRL, 1, rd, err);
            send_samples(r.periods * r.len, r.gap);
         end
         default: begin
            send_samples(r.periods * r.len, r.gap);
         end
      endcase
      wait_pulses(base + r.periods);
      total = chk_pulses;
      if (r.mode == MODE_DISABLE) begin
         apb_access(1'b0, corr_pkg::ADDR_COUNT, 0, rd, err);
         check_value("COUNT", total, rd);
      end
      apb_access(1'b1, corr_pkg::ADDR_CTRL, 0, rd, err);
      @(posedge clk);
      $display("Test %0d (%s): len %0d, %0d results, %0d errors", idx + 1,
               mode_name(r.mode), r.len, total - base, tb_errors + chk_errors - err0);
   endtask

   initial begin : main
      int i;
      int total_errors;
      rst_n        = 1'b0;
      psel         = 1'b0;
      penable      = 1'b0;
      pwrite       = 1'b0;
      paddr        = '0;
      pwdata       = '0;
      sample_valid = 1'b0;
      sample_i     = '0;
      sample_q     = '0;
      code_chip    = 1'b0;
      repeat (8) @(negedge clk);
      rst_n = 1'b1;
      register_test();
      for (i = 0; i < NUM_TESTS; i++) begin
         run_row(i);
      end
      @(posedge clk);
      total_errors = tb_errors + chk_errors;
      $display("Tests %0d, checks %0d, errors %0d", NUM_TESTS + 1,
               tb_checks + chk_checks, total_errors);
      if (total_errors == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

/* project.f */
hdl/corr_pkg.sv
hdl/tap_bus_if.sv
hdl/apb_regs.sv
hdl/code_tap_line.sv
hdl/correlator.sv
hdl/power_detector.sv
hdl/channel_top.sv
dv/channel_checker.sv
dv/tb_channel.sv

/* run.sh */
#!/bin/sh
# Build and run the correlator channel testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary -f project.f --top-module tb_channel -Mdir obj_dir -o sim_channel
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit 1
fi

./obj_dir/sim_channel > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q '^>>> PASS$' sim.log; then
   exit 0
fi
echo "Pass message not found in sim.log"
exit 1
